/* rtl/clock_pkg.sv */
package clock_pkg;

  // seconds counted from the start stamp
  typedef logic [31:0] stamp_t;

  // second of the day, 0 to 86399
  typedef logic [16:0] sod_t;

  // two BCD digits per field
  typedef struct packed {
    logic [7:0] hour;
    logic [7:0] minute;
    logic [7:0] second;
  } bcd_hms_t;

  localparam int unsigned SECONDS_PER_DAY    = 86400;
  localparam int unsigned SECONDS_PER_HOUR   = 3600;
  localparam int unsigned SECONDS_PER_MINUTE = 60;

endpackage

/* rtl/alarm_pkg.sv */
package alarm_pkg;

  // slot index, 3 falls back to slot 0
  typedef logic [1:0] alarm_sel_t;

  // beep pattern, in clock cycles
  localparam int unsigned RING_ON_FIRST  = 5;
  localparam int unsigned RING_OFF       = 10;
  localparam int unsigned RING_ON_SECOND = 5;

endpackage

/* rtl/stamp_conv_if.sv */
`timescale 1ns/1ps

interface stamp_conv_if import clock_pkg::*; ();

  // level, held with stamp until done
  logic     req;
  stamp_t   stamp;
  // one-cycle pulse, result valid with it
  logic     done;
  bcd_hms_t result;

  modport requester (
    output req,
    output stamp,
    input  done,
    input  result
  );

  modport server (
    input  req,
    input  stamp,
    output done,
    output result
  );

endinterface

/* rtl/seconds_counter.sv */
`timescale 1ns/1ps

module seconds_counter import clock_pkg::*; #(
  parameter int unsigned TICK_DIV    = 50_000_000,
  parameter stamp_t      START_STAMP = '0
) (
  input  logic   clk,
  input  logic   rst_n,
  output logic   tick,
  output stamp_t stamp,
  output sod_t   sod
);

  localparam int   DIV_W     = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam sod_t START_SOD = sod_t'(START_STAMP % SECONDS_PER_DAY);

  logic [DIV_W-1:0] div_cnt;

  // last cycle of each second
  assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // sod runs next to the stamp so the day boundary needs no division
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stamp <= START_STAMP;
      sod   <= START_SOD;
    end else if (tick) begin
      stamp <= stamp + 1'b1;
      sod   <= (sod == sod_t'(SECONDS_PER_DAY - 1)) ? '0 : sod + 1'b1;
    end
  end

endmodule

/* rtl/stamp_to_bcd.sv */
`timescale 1ns/1ps

module stamp_to_bcd import clock_pkg::*; (
  input logic          clk,
  input logic          rst_n,
  stamp_conv_if.server conv
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_MOD,
    S_DIGIT,
    S_DONE
  } state_t;

  state_t          state;
  logic [3:0]      step_cnt;
  logic [2:0]      digit_idx;
  stamp_t          rem;
  stamp_t          divisor;
  stamp_t          weight;
  logic            digit_done;
  logic [4:0][3:0] digit;

  // place value of the digit being counted, hour tens first
  always_comb begin
    case (digit_idx)
      3'd0:    weight = stamp_t'(10 * SECONDS_PER_HOUR);
      3'd1:    weight = stamp_t'(SECONDS_PER_HOUR);
      3'd2:    weight = stamp_t'(10 * SECONDS_PER_MINUTE);
      3'd3:    weight = stamp_t'(SECONDS_PER_MINUTE);
      default: weight = stamp_t'(10);
    endcase
  end

  assign digit_done = (rem < weight);
  assign conv.done  = (state == S_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      step_cnt  <= '0;
      digit_idx <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (conv.req) begin
            state    <= S_MOD;
            step_cnt <= 4'd15;
          end
        end
        S_MOD: begin
          step_cnt <= step_cnt - 4'd1;
          if (step_cnt == 4'd0) begin
            state     <= S_DIGIT;
            digit_idx <= '0;
          end
        end
        S_DIGIT: begin
          if (digit_done) begin
            if (digit_idx == 3'd4) begin
              state <= S_DONE;
            end else begin
              digit_idx <= digit_idx + 3'd1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // quotient fits 16 bits, so 16 shift-subtract steps leave stamp mod day
  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        if (conv.req) begin
          rem     <= conv.stamp;
          divisor <= stamp_t'(SECONDS_PER_DAY) << 15;
          digit   <= '0;
        end
      end
      S_MOD: begin
        if (rem >= divisor) begin
          rem <= rem - divisor;
        end
        divisor <= divisor >> 1;
      end
      S_DIGIT: begin
        if (!digit_done) begin
          rem               <= rem - weight;
          digit[digit_idx] <= digit[digit_idx] + 4'd1;
        end else if (digit_idx == 3'd4) begin
          // what is left below ten is the seconds units digit
          conv.result <= '{hour:   {digit[0], digit[1]},
                           minute: {digit[2], digit[3]},
                           second: {digit[4], rem[3:0]}};
        end
      end
      default: ;
    endcase
  end

endmodule

/* rtl/conv_arbiter.sv */
`timescale 1ns/1ps

module conv_arbiter (
  input logic             clk,
  input logic             rst_n,
  stamp_conv_if.server    req_a,
  stamp_conv_if.server    req_b,
  stamp_conv_if.requester conv
);

  // one-hot owner {b, a}, zero while the converter is free
  logic [1:0] owner;
  logic       last_b;
  logic       grant_b;

  // b wins when alone or when a had the last turn
  assign grant_b = req_b.req & (~req_a.req | ~last_b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner  <= '0;
      last_b <= 1'b1;
    end else if (owner == 2'b00) begin
      if (req_a.req || req_b.req) begin
        owner  <= {grant_b, ~grant_b};
        last_b <= grant_b;
      end
    end else if (conv.done) begin
      owner <= '0;
    end
  end

  assign conv.req   = |owner;
  assign conv.stamp = owner[1] ? req_b.stamp : req_a.stamp;

  // only the owner sees done and result
  assign req_a.done   = conv.done & owner[0];
  assign req_b.done   = conv.done & owner[1];
  assign req_a.result = owner[0] ? conv.result : '0;
  assign req_b.result = owner[1] ? conv.result : '0;

endmodule

/* rtl/time_display.sv */
`timescale 1ns/1ps

module time_display import clock_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            tick,
  input  stamp_t          stamp,
  stamp_conv_if.requester conv,
  output bcd_hms_t        time_bcd
);

  logic pending;
  logic launch;

  // stamp still holds the old second in the tick cycle, so launch a cycle later
  assign launch = pending & ~conv.req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending  <= 1'b0;
      conv.req <= 1'b0;
      time_bcd <= '0;
    end else begin
      pending <= tick | (pending & ~launch);
      if (conv.done) begin
        conv.req <= 1'b0;
        time_bcd <= conv.result;
      end else if (launch) begin
        conv.req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      conv.stamp <= stamp;
    end
  end

endmodule

/* rtl/alarm_unit.sv */
`timescale 1ns/1ps

module alarm_unit import clock_pkg::*, alarm_pkg::*; #(
  parameter int unsigned NUM_ALARMS = 3
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            set,
  input  logic            cancel,
  input  logic            tick,
  input  alarm_sel_t      sel,
  input  bcd_hms_t        alarm_in,
  input  stamp_t          stamp,
  input  sod_t            sod,
  stamp_conv_if.requester conv,
  output bcd_hms_t        alarm_bcd,
  output logic            ring
);

  localparam int RING_LEN = RING_ON_FIRST + RING_OFF + RING_ON_SECOND;
  localparam int CNT_W    = $clog2(RING_LEN);

  stamp_t           slot_stamp [NUM_ALARMS];
  alarm_sel_t       cur_slot;
  alarm_sel_t       sel_q;
  sod_t             target;
  stamp_t           new_alarm;
  stamp_t           next_stamp;
  logic             match;
  logic             ring_active;
  logic [CNT_W-1:0] ring_cnt;
  logic             pending;
  logic             launch;

  function automatic logic [6:0] bcd_to_bin(input logic [7:0] bcd);
    return 7'(bcd[7:4]) * 7'd10 + 7'(bcd[3:0]);
  endfunction

  // unused indices, 3 included, fall back to slot 0
  assign cur_slot = (sel < NUM_ALARMS) ? sel : '0;

  assign target = sod_t'(bcd_to_bin(alarm_in.hour) * SECONDS_PER_HOUR +
                         bcd_to_bin(alarm_in.minute) * SECONDS_PER_MINUTE +
                         bcd_to_bin(alarm_in.second));

  // today if still ahead, otherwise tomorrow
  assign new_alarm = stamp - stamp_t'(sod) + stamp_t'(target) +
                     ((target <= sod) ? stamp_t'(SECONDS_PER_DAY) : stamp_t'(0));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ALARMS; i++) begin
        slot_stamp[i] <= '0;
      end
    end else if (set) begin
      slot_stamp[cur_slot] <= new_alarm;
    end
  end

  // compare against the stamp this tick is about to load
  assign next_stamp = stamp + 1'b1;

  always_comb begin
    match = 1'b0;
    if (tick) begin
      for (int i = 0; i < NUM_ALARMS; i++) begin
        if (slot_stamp[i] == next_stamp) begin
          match = 1'b1;
        end
      end
    end
  end

  // a fresh match restarts the pattern
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ring_active <= 1'b0;
      ring_cnt    <= '0;
    end else if (match) begin
      ring_active <= 1'b1;
      ring_cnt    <= '0;
    end else if (cancel) begin
      ring_active <= 1'b0;
      ring_cnt    <= '0;
    end else if (ring_active) begin
      if (ring_cnt == CNT_W'(RING_LEN - 1)) begin
        ring_active <= 1'b0;
        ring_cnt    <= '0;
      end else begin
        ring_cnt <= ring_cnt + 1'b1;
      end
    end
  end

  // high, gap, high
  assign ring = ring_active &
                ((ring_cnt < CNT_W'(RING_ON_FIRST)) |
                 (ring_cnt >= CNT_W'(RING_ON_FIRST + RING_OFF)));

  assign launch = pending & ~conv.req;

  // read-back once after reset, on a new sel and after each set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q     <= '0;
      pending   <= 1'b1;
      conv.req  <= 1'b0;
      alarm_bcd <= '0;
    end else begin
      sel_q   <= sel;
      pending <= (sel != sel_q) | set | (pending & ~launch);
      if (conv.done) begin
        conv.req  <= 1'b0;
        alarm_bcd <= conv.result;
      end else if (launch) begin
        conv.req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      conv.stamp <= slot_stamp[cur_slot];
    end
  end

endmodule

/* rtl/alarm_clock_top.sv */
`timescale 1ns/1ps

module alarm_clock_top import clock_pkg::*; #(
  parameter int unsigned TICK_DIV    = 50_000_000,
  parameter stamp_t      START_STAMP = '0,
  parameter int unsigned NUM_ALARMS  = 3
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       set,
  input  logic       cancel,
  input  logic [1:0] sel,
  input  logic [7:0] alarm_hour_in,
  input  logic [7:0] alarm_minute_in,
  input  logic [7:0] alarm_second_in,
  output logic [7:0] time_hour,
  output logic [7:0] time_minute,
  output logic [7:0] time_second,
  output logic [7:0] alarm_hour,
  output logic [7:0] alarm_minute,
  output logic [7:0] alarm_second,
  output logic       ring
);

  logic     tick;
  stamp_t   stamp;
  sod_t     sod;
  bcd_hms_t time_bcd;
  bcd_hms_t alarm_bcd;
  bcd_hms_t alarm_in;

  // display and read-back share the one converter
  stamp_conv_if disp_conv ();
  stamp_conv_if alarm_conv ();
  stamp_conv_if core_conv ();

  assign alarm_in = '{hour: alarm_hour_in, minute: alarm_minute_in, second: alarm_second_in};

  seconds_counter #(
    .TICK_DIV    (TICK_DIV),
    .START_STAMP (START_STAMP)
  ) u_seconds_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick),
    .stamp (stamp),
    .sod   (sod)
  );

  time_display u_time_display (
    .clk      (clk),
    .rst_n    (rst_n),
    .tick     (tick),
    .stamp    (stamp),
    .conv     (disp_conv.requester),
    .time_bcd (time_bcd)
  );

  alarm_unit #(
    .NUM_ALARMS (NUM_ALARMS)
  ) u_alarm_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .set       (set),
    .cancel    (cancel),
    .tick      (tick),
    .sel       (sel),
    .alarm_in  (alarm_in),
    .stamp     (stamp),
    .sod       (sod),
    .conv      (alarm_conv.requester),
    .alarm_bcd (alarm_bcd),
    .ring      (ring)
  );

  conv_arbiter u_conv_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .req_a (disp_conv.server),
    .req_b (alarm_conv.server),
    .conv  (core_conv.requester)
  );

  stamp_to_bcd u_stamp_to_bcd (
    .clk   (clk),
    .rst_n (rst_n),
    .conv  (core_conv.server)
  );

  assign time_hour    = time_bcd.hour;
  assign time_minute  = time_bcd.minute;
  assign time_second  = time_bcd.second;
  assign alarm_hour   = alarm_bcd.hour;
  assign alarm_minute = alarm_bcd.minute;
  assign alarm_second = alarm_bcd.second;

endmodule

/* verif/alarm_clock_tb.sv */
`timescale 1ns/1ps

module alarm_clock_tb import clock_pkg::*, alarm_pkg::*; ();

  localparam int unsigned TICK_DIV        = 200;
  localparam stamp_t      START_STAMP     = 86395;
  localparam int          DISPLAY_WAIT    = 130;
  // the tests take about 27 seconds of clock time
  localparam int          WATCHDOG_CYCLES = 40 * TICK_DIV;
  localparam int          RING_LEN        = RING_ON_FIRST + RING_OFF + RING_ON_SECOND;

  logic       clk;
  logic       rst_n;
  logic       set;
  logic       cancel;
  logic [1:0] sel;
  logic [7:0] alarm_hour_in;
  logic [7:0] alarm_minute_in;
  logic [7:0] alarm_second_in;
  logic [7:0] time_hour;
  logic [7:0] time_minute;
  logic [7:0] time_second;
  logic [7:0] alarm_hour;
  logic [7:0] alarm_minute;
  logic [7:0] alarm_second;
  logic       ring;

  // reference model state
  int unsigned sub_cnt;
  int unsigned tick_count;
  stamp_t      m_stamp;
  stamp_t      m_alarm [3];
  logic        m_tick;
  logic        ring_hit;
  logic        r_active;
  int unsigned r_off;
  logic        ring_exp;

  logic [15:0] lfsr = 16'd10595;
  int          err_count;
  int          test_err [1:6];
  int          ring_test;
  int          tests_passed;
  int          tests_failed;

  alarm_clock_top #(
    .TICK_DIV    (TICK_DIV),
    .START_STAMP (START_STAMP),
    .NUM_ALARMS  (3)
  ) u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .set             (set),
    .cancel          (cancel),
    .sel             (sel),
    .alarm_hour_in   (alarm_hour_in),
    .alarm_minute_in (alarm_minute_in),
    .alarm_second_in (alarm_second_in),
    .time_hour       (time_hour),
    .time_minute     (time_minute),
    .time_second     (time_second),
    .alarm_hour      (alarm_hour),
    .alarm_minute    (alarm_minute),
    .alarm_second    (alarm_second),
    .ring            (ring)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic note_error(int id, string msg);
    $display("error %0d ns: test %0d: %s", $time, id, msg);
    test_err[id]++;
    err_count++;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic int unsigned random_bits(int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | int'(next_random_bit());
    end
    return r;
  endfunction

  function automatic int unsigned from_bcd(logic [7:0] b);
    return b[7:4] * 10 + b[3:0];
  endfunction

  function automatic logic [7:0] to_bcd2(int unsigned v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  function automatic bcd_hms_t expected_time(stamp_t s);
    int unsigned day_sec;
    day_sec = s % SECONDS_PER_DAY;
    return '{hour:   to_bcd2(day_sec / SECONDS_PER_HOUR),
             minute: to_bcd2((day_sec % SECONDS_PER_HOUR) / SECONDS_PER_MINUTE),
             second: to_bcd2(day_sec % SECONDS_PER_MINUTE)};
  endfunction

  function automatic bcd_hms_t random_time();
    int unsigned h;
    int unsigned m;
    int unsigned s;
    h = random_bits(5) % 24;
    m = random_bits(6) % 60;
    s = random_bits(6) % 60;
    return '{hour: to_bcd2(h), minute: to_bcd2(m), second: to_bcd2(s)};
  endfunction

  // today if the time is still ahead, tomorrow otherwise
  function automatic stamp_t alarm_stamp(stamp_t now, bcd_hms_t a);
    int unsigned day_sec;
    int unsigned target;
    day_sec = now % SECONDS_PER_DAY;
    target  = from_bcd(a.hour) * SECONDS_PER_HOUR + from_bcd(a.minute) * SECONDS_PER_MINUTE +
              from_bcd(a.second);
    if (target > day_sec) begin
      return now - day_sec + target;
    end
    return now - day_sec + target + SECONDS_PER_DAY;
  endfunction

  assign m_tick   = rst_n && (sub_cnt == TICK_DIV - 1);
  assign ring_hit = m_tick && (m_alarm[0] == m_stamp + 1 || m_alarm[1] == m_stamp + 1 ||
                               m_alarm[2] == m_stamp + 1);
  assign ring_exp = r_active && (r_off < RING_ON_FIRST ||
                                 (r_off >= RING_ON_FIRST + RING_OFF && r_off < RING_LEN));

  always @(posedge clk) begin
    if (!rst_n) begin
      sub_cnt    <= 0;
      tick_count <= 0;
      m_stamp    <= START_STAMP;
      r_active   <= 1'b0;
      r_off      <= 0;
      for (int i = 0; i < 3; i++) begin
        m_alarm[i] <= '0;
      end
    end else begin
      if (m_tick) begin
        sub_cnt    <= 0;
        tick_count <= tick_count + 1;
        m_stamp    <= m_stamp + 1;
      end else begin
        sub_cnt <= sub_cnt + 1;
      end
      if (set) begin
        m_alarm[(sel == 2'd3) ? 2'd0 : sel] <= alarm_stamp(m_stamp,
            '{hour: alarm_hour_in, minute: alarm_minute_in, second: alarm_second_in});
      end
      if (ring_hit) begin
        r_active <= 1'b1;
        r_off    <= 0;
      end else if (cancel) begin
        r_active <= 1'b0;
      end else if (r_active) begin
        r_off <= r_off + 1;
      end
    end
  end

  // ring follows the model at every cycle
  always @(negedge clk) begin
    if (rst_n) begin
      assert (ring === ring_exp)
        else note_error(ring_test, $sformatf("ring is %b, expected %b", ring, ring_exp));
    end
  end

  cancel_ends_ring: assert property (@(posedge clk) disable iff (!rst_n)
                                     (cancel && !ring_hit) |=> !ring)
    else note_error(4, "ring still high one cycle after cancel");

  task automatic wait_tick_edge();
    @(negedge clk);
    while (!m_tick) @(negedge clk);
    @(negedge clk);
  endtask

  // stops in the tick cycle that loads stamp s
  task automatic wait_load(stamp_t s);
    @(negedge clk);
    while (!(m_tick && m_stamp + 1 == s)) @(negedge clk);
  endtask

  task automatic set_alarm(int slot, bcd_hms_t val);
    @(posedge clk);
    sel             <= 2'(slot);
    alarm_hour_in   <= val.hour;
    alarm_minute_in <= val.minute;
    alarm_second_in <= val.second;
    set             <= 1'b1;
    @(posedge clk);
    set <= 1'b0;
  endtask

  task automatic display_test();
    bcd_hms_t exp;
    bcd_hms_t shown;
    repeat (10) begin
      wait_tick_edge();
      repeat (DISPLAY_WAIT - 1) @(negedge clk);
      exp   = expected_time(m_stamp);
      shown = '{hour: time_hour, minute: time_minute, second: time_second};
      assert (shown == exp)
        else note_error(1, $sformatf("display %h:%h:%h, expected %h:%h:%h", shown.hour,
                                     shown.minute, shown.second, exp.hour, exp.minute,
                                     exp.second));
    end
  endtask

  task automatic next_day_test();
    int unsigned start;
    int          rises;
    logic        prev;
    rises = 0;
    prev  = 1'b0;
    set_alarm(0, '{hour: 8'h00, minute: 8'h00, second: 8'h02});
    // already passed today
    set_alarm(1, '{hour: 8'h23, minute: 8'h59, second: 8'h50});
    start = tick_count;
    @(negedge clk);
    while (tick_count < start + 10) begin
      if (ring && !prev) begin
        if (rises == 0) begin
          assert (m_stamp == 86402 && sub_cnt == 0)
            else note_error(5, $sformatf("ring rose at stamp %0d, expected 86402", m_stamp));
        end
        rises++;
      end
      prev = ring;
      @(negedge clk);
    end
    assert (rises == 2)
      else note_error(5, $sformatf("ring rose %0d times in 10 seconds, expected 2", rises));
  endtask

  task automatic readback_test();
    bcd_hms_t vals [3];
    bcd_hms_t shown;
    int       waited;
    for (int i = 0; i < 3; i++) begin
      vals[i] = random_time();
      set_alarm(i, vals[i]);
    end
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      sel <= 2'(i);
      waited = 0;
      @(negedge clk);
      shown = '{hour: alarm_hour, minute: alarm_minute, second: alarm_second};
      while (shown != vals[i] && waited < DISPLAY_WAIT) begin
        @(negedge clk);
        waited++;
        shown = '{hour: alarm_hour, minute: alarm_minute, second: alarm_second};
      end
      assert (shown == vals[i])
        else note_error(2, $sformatf("slot %0d shows %h:%h:%h, expected %h:%h:%h", i,
                                     shown.hour, shown.minute, shown.second, vals[i].hour,
                                     vals[i].minute, vals[i].second));
    end
  endtask

  task automatic ring_pattern_test();
    stamp_t s;
    logic   exp;
    wait_tick_edge();
    s = m_stamp;
    set_alarm(2, expected_time(s + 3));
    wait_load(s + 3);
    assert (!ring) else note_error(3, "ring high before the alarm tick");
    for (int k = 0; k < RING_LEN + 5; k++) begin
      @(negedge clk);
      exp = (k < RING_ON_FIRST) || (k >= RING_ON_FIRST + RING_OFF && k < RING_LEN);
      assert (ring == exp)
        else note_error(3, $sformatf("ring %b in pattern cycle %0d, expected %b", ring, k, exp));
    end
  endtask

  task automatic cancel_test();
    stamp_t s;
    int     delay;
    wait_tick_edge();
    s = m_stamp;
    set_alarm(2, expected_time(s + 3));
    // cancel lands in a high cycle of either beep
    delay = random_bits(3);
    if (delay >= 4) begin
      delay = delay + 10;
    end
    wait_load(s + 3);
    @(negedge clk);
    assert (ring) else note_error(4, "ring did not start at the alarm tick");
    repeat (delay + 1) @(posedge clk);
    cancel <= 1'b1;
    @(posedge clk);
    cancel <= 1'b0;
    for (int k = 0; k < 40; k++) begin
      @(negedge clk);
      assert (!ring) else note_error(4, $sformatf("ring high %0d cycles after cancel", k + 1));
    end
  endtask

  task automatic multi_slot_test();
    stamp_t s;
    wait_tick_edge();
    s = m_stamp;
    set_alarm(0, expected_time(s + 3));
    set_alarm(1, expected_time(s + 5));
    for (int k = 3; k <= 5; k += 2) begin
      wait_load(s + k);
      assert (!ring) else note_error(6, "ring high before the alarm tick");
      @(negedge clk);
      assert (ring)
        else note_error(6, $sformatf("ring did not start at stamp %0d", s + stamp_t'(k)));
    end
    repeat (RING_LEN + 10) @(negedge clk);
  endtask

  task automatic report_test(int id, string name);
    if (test_err[id] == 0) begin
      tests_passed++;
      $display("test %0d %s: pass", id, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail with %0d errors", id, name, test_err[id]);
    end
  endtask

  initial begin
    rst_n           = 1'b0;
    set             = 1'b0;
    cancel          = 1'b0;
    sel             = 2'd0;
    alarm_hour_in   = 8'h00;
    alarm_minute_in = 8'h00;
    alarm_second_in = 8'h00;
    ring_test       = 1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (ring == 1'b0 && {time_hour, time_minute, time_second} == '0 &&
            {alarm_hour, alarm_minute, alarm_second} == '0)
      else note_error(1, "outputs are not zero during reset");
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // 00:00:02 must fire before the display passes it
    ring_test = 5;
    fork
      display_test();
      next_day_test();
    join
    report_test(1, "time display");
    report_test(5, "next-day rule");
    ring_test = 2;
    readback_test();
    report_test(2, "alarm read-back");
    ring_test = 3;
    ring_pattern_test();
    report_test(3, "ring pattern");
    ring_test = 4;
    cancel_test();
    report_test(4, "cancel");
    ring_test = 6;
    multi_slot_test();
    report_test(6, "multiple slots");

    $display("%0d tests: %0d passed, %0d failed, %0d errors", tests_passed + tests_failed,
             tests_passed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* tb.f */
rtl/clock_pkg.sv
rtl/alarm_pkg.sv
rtl/stamp_conv_if.sv
rtl/seconds_counter.sv
rtl/stamp_to_bcd.sv
rtl/conv_arbiter.sv
rtl/time_display.sv
rtl/alarm_unit.sv
rtl/alarm_clock_top.sv
verif/alarm_clock_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the alarm clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module alarm_clock_tb -f tb.f -o alarm_clock_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/alarm_clock_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0
